/* source/mcu_io_pkg.sv */
// I/O hub shared definitions
// Data widths, I/O address map, interrupt slots and UART timing

package mcu_io_pkg;

  // Bus and cell widths
  localparam int IO_WIDTH  = 24;                  // Processor data cell
  localparam int IO_ADDR_W = 15;                  // I/O address
  localparam int WB_DATA_W = 32;                  // Wishbone data
  localparam int WB_ADDR_W = 15;                  // Wishbone address

  // Serial timing
  localparam logic [15:0] UART_PERIOD = 16'd8;    // Clocks per serial bit

  // Interrupts
  localparam int IRQS      = 2;                   // External request lines
  localparam int IRQ_NUM   = 8;                   // Pending slots, slot 0 unused
  localparam int IRQ_CYCLE = 1;                   // Timer overflow
  localparam int IRQ_UTX   = 2;                   // UART ready for next byte
  localparam int IRQ_URX   = 3;                   // UART byte received
  localparam int IRQ_EXT0  = 4;                   // First external line

  // I/O address map
  localparam logic [14:0] A_UART_DATA = 15'd0;    // Rx byte / tx byte
  localparam logic [14:0] A_UART_STAT = 15'd1;    // Tx ready, rx full
  localparam logic [14:0] A_TIMER     = 15'd2;    // Count / reload period
  localparam logic [14:0] A_IRQ_PEND  = 15'd3;    // Pending slots
  localparam logic [14:0] A_WB_ADR    = 15'd4;    // Bus address
  localparam logic [14:0] A_WB_DLO    = 15'd5;    // Data bits 23:0
  localparam logic [14:0] A_WB_DHI    = 15'd6;    // Data bits 31:24, write starts
  localparam logic [14:0] A_WB_RD     = 15'd7;    // Starts a bus read

endpackage

/* source/io_decode.sv */
// I/O space decoder
// Turns processor read and write strobes into one-cycle peripheral strobes
// and returns the addressed read word one cycle after the read strobe

module io_decode (
  input  logic                                clk,
  input  logic                                p_reset_n,
  input  logic                                io_rd_i,        // Processor read strobe
  input  logic                                io_wr_i,        // Processor write strobe
  input  logic [mcu_io_pkg::IO_ADDR_W-1:0]    io_addr_i,
  input  logic [mcu_io_pkg::IO_WIDTH-1:0]     io_din_i,       // Write data, used by peripherals
  output logic [mcu_io_pkg::IO_WIDTH-1:0]     io_dout_o,      // Registered read data
  // UART side
  output logic                                u_wr_o,         // Send a byte
  output logic                                u_rd_o,         // Byte taken, clears full
  input  logic [7:0]                          u_rx_data_i,
  input  logic                                u_tx_ready_i,
  input  logic                                u_rx_full_i,
  // Timer and interrupt side
  output logic                                t_wr_o,         // Load reload period
  input  logic [mcu_io_pkg::IO_WIDTH-1:0]     t_count_i,
  input  logic [mcu_io_pkg::IRQ_NUM-1:0]      ipend_i,
  // Bridge side
  output logic                                wb_adr_wr_o,
  output logic                                wb_dlo_wr_o,
  output logic                                wb_dhi_wr_o,    // Also starts a bus write
  output logic                                wb_rd_go_o,     // Starts a bus read
  input  logic [mcu_io_pkg::WB_DATA_W-1:0]    wb_rdata_i
);
  import mcu_io_pkg::*;

  logic                sel_udata;                 // Address hits
  logic                sel_ustat;
  logic                sel_timer;
  logic                sel_ipend;
  logic                sel_wbadr;
  logic                sel_wbdlo;
  logic                sel_wbdhi;
  logic                sel_wbrd;
  logic [IO_WIDTH-1:0] rd_word;                   // Read value before the register

  assign sel_udata = (io_addr_i == A_UART_DATA);
  assign sel_ustat = (io_addr_i == A_UART_STAT);
  assign sel_timer = (io_addr_i == A_TIMER);
  assign sel_ipend = (io_addr_i == A_IRQ_PEND);
  assign sel_wbadr = (io_addr_i == A_WB_ADR);
  assign sel_wbdlo = (io_addr_i == A_WB_DLO);
  assign sel_wbdhi = (io_addr_i == A_WB_DHI);
  assign sel_wbrd  = (io_addr_i == A_WB_RD);

  // Write side strobes, peripherals act at the next edge
  assign u_wr_o      = io_wr_i & sel_udata;
  assign t_wr_o      = io_wr_i & sel_timer;
  assign wb_adr_wr_o = io_wr_i & sel_wbadr;
  assign wb_dlo_wr_o = io_wr_i & sel_wbdlo;
  assign wb_dhi_wr_o = io_wr_i & sel_wbdhi;
  assign wb_rd_go_o  = io_wr_i & sel_wbrd;

  // Read side strobe, taking the rx byte empties the UART
  assign u_rd_o = io_rd_i & sel_udata;

  // Read multiplexer
  always_comb begin
    rd_word = '0;                                 // Unmapped and write-only read zero
    if (sel_udata) begin
      rd_word = IO_WIDTH'(u_rx_data_i);
    end else if (sel_ustat) begin
      rd_word = IO_WIDTH'({u_rx_full_i, u_tx_ready_i});
    end else if (sel_timer) begin
      rd_word = t_count_i;
    end else if (sel_ipend) begin
      rd_word = IO_WIDTH'(ipend_i);
    end else if (sel_wbdlo) begin
      rd_word = wb_rdata_i[IO_WIDTH-1:0];         // Low 24 bits
    end else if (sel_wbdhi) begin
      rd_word = IO_WIDTH'(wb_rdata_i[WB_DATA_W-1:IO_WIDTH]);  // High 8 bits
    end
  end

  // Read word holds until the next read
  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      io_dout_o <= '0;
    end else if (io_rd_i) begin
      io_dout_o <= rd_word;
    end
  end

endmodule

/* source/uart.sv */
// Byte-wide UART
// 8N1 transmitter and receiver at a fixed bit period, rx input
// passes a two-flop synchronizer before the start-bit search

module uart (
  input  logic       clk,
  input  logic       p_reset_n,
  input  logic       wr_i,                        // Send din_i
  input  logic [7:0] din_i,
  output logic       ready_o,                     // Transmitter idle
  input  logic       rd_i,                        // Byte taken
  output logic [7:0] dout_o,                      // Last received byte
  output logic       full_o,                      // Received byte waiting
  input  logic       rxd_i,                       // Asynchronous serial in
  output logic       txd_o
);
  import mcu_io_pkg::*;

  // Transmitter state
  logic [9:0]  tx_sr;                             // Stop, data, start, LSB out first
  logic        tx_busy;
  logic [15:0] tx_cnt;                            // Clocks within a bit
  logic [3:0]  tx_bits;                           // Bits sent of this frame

  // Receiver state
  logic        rx_s1;                             // Synchronizer stages
  logic        rx_s2;
  logic        rx_busy;                           // Frame in progress
  logic [15:0] rx_cnt;                            // Clocks to the next sample
  logic [3:0]  rx_bits;                           // 0 start, 1..8 data, 9 stop
  logic        rx_tick;                           // Sample point
  logic [7:0]  rx_sr;                             // Incoming data bits
  logic [7:0]  rx_data;                           // Completed byte
  logic        rx_full;

  assign txd_o   = tx_sr[0];
  assign ready_o = ~tx_busy;
  assign dout_o  = rx_data;
  assign full_o  = rx_full;

  // Transmit one frame per accepted write
  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      tx_sr   <= '1;                              // Line idles high
      tx_busy <= 1'b0;
      tx_cnt  <= '0;
      tx_bits <= '0;
    end else if (wr_i && !tx_busy) begin
      tx_sr   <= {1'b1, din_i, 1'b0};
      tx_busy <= 1'b1;
      tx_cnt  <= '0;
      tx_bits <= '0;
    end else if (tx_busy) begin
      if (tx_cnt == UART_PERIOD - 16'd1) begin
        tx_cnt <= '0;
        tx_sr  <= {1'b1, tx_sr[9:1]};             // Next bit, fill with idle
        if (tx_bits == 4'd9) begin
          tx_busy <= 1'b0;                        // Stop bit done
        end else begin
          tx_bits <= tx_bits + 4'd1;
        end
      end else begin
        tx_cnt <= tx_cnt + 16'd1;
      end
    end
  end

  assign rx_tick = rx_busy && (rx_cnt == '0);

  // Receiver control
  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_busy <= 1'b0;
      rx_cnt  <= '0;
      rx_bits <= '0;
      rx_full <= 1'b0;
    end else begin
      rx_s1 <= rxd_i;
      rx_s2 <= rx_s1;
      if (rd_i) begin
        rx_full <= 1'b0;
      end
      if (!rx_busy) begin
        if (!rx_s2) begin                         // Start bit edge
          rx_busy <= 1'b1;
          rx_cnt  <= (UART_PERIOD >> 1) - 16'd1;  // Go to mid start bit
          rx_bits <= '0;
        end
      end else if (rx_tick) begin
        rx_cnt  <= UART_PERIOD - 16'd1;
        rx_bits <= rx_bits + 4'd1;
        if (rx_bits == 4'd0 && rx_s2) begin
          rx_busy <= 1'b0;                        // Glitch, not a start bit
        end
        if (rx_bits == 4'd9) begin
          rx_busy <= 1'b0;
          if (rx_s2) begin
            rx_full <= 1'b1;                      // Wins over a same-cycle read
          end
        end
      end else begin
        rx_cnt <= rx_cnt - 16'd1;
      end
    end
  end

  // Receiver data path
  always_ff @(posedge clk) begin
    if (rx_tick && rx_bits != 4'd0 && rx_bits != 4'd9) begin
      rx_sr <= {rx_s2, rx_sr[7:1]};               // LSB arrives first
    end
    if (rx_tick && rx_bits == 4'd9 && rx_s2) begin
      rx_data <= rx_sr;                           // Overwrites an unread byte
    end
  end

endmodule

/* source/irq_ctrl.sv */
// Interrupt controller
// Reloadable cycle timer, latched request slots and a priority vector
// for the highest pending slot

module irq_ctrl (
  input  logic                                clk,
  input  logic                                p_reset_n,
  input  logic                                t_wr_i,         // Load reload period
  input  logic [mcu_io_pkg::IO_WIDTH-1:0]     t_period_i,
  output logic [mcu_io_pkg::IO_WIDTH-1:0]     t_count_o,
  input  logic                                tx_ready_i,
  input  logic                                rx_full_i,
  input  logic [mcu_io_pkg::IRQS-1:0]         irqs_i,         // External strobes
  input  logic                                iack_i,         // Clears slot ivec_o
  output logic [mcu_io_pkg::IRQ_NUM-1:0]      ipend_o,
  output logic                                irq_o,
  output logic [2:0]                          ivec_o
);
  import mcu_io_pkg::*;

  logic [IO_WIDTH-1:0] period;                    // 0 stops the timer
  logic [IO_WIDTH-1:0] count;
  logic                cyc_ev;                    // Timer wraps this cycle
  logic                tx_ready_d;                // Edge detect history
  logic                rx_full_d;
  logic [IRQ_NUM-1:0]  ireq;                      // New requests
  logic [IRQ_NUM-1:0]  iclr;                      // Acknowledged slot
  logic [IRQ_NUM-1:0]  ipend;

  assign cyc_ev = (period != '0) && (count == period) && !t_wr_i;

  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      period <= '0;
      count  <= '0;
    end else if (t_wr_i) begin
      period <= t_period_i;
      count  <= '0;                               // Keeps count within the period
    end else if (cyc_ev) begin
      count <= '0;
    end else if (period != '0) begin
      count <= count + 1'b1;
    end
  end

  always_comb begin
    ireq                   = '0;
    ireq[IRQ_CYCLE]        = cyc_ev;
    ireq[IRQ_UTX]          = tx_ready_i & ~tx_ready_d;   // Rising edges only
    ireq[IRQ_URX]          = rx_full_i & ~rx_full_d;
    ireq[IRQ_EXT0 +: IRQS] = irqs_i;
  end

  assign iclr = iack_i ? (IRQ_NUM'(1) << ivec_o) : '0;

  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      tx_ready_d <= 1'b1;                         // Ready is high out of reset
      rx_full_d  <= 1'b0;
      ipend      <= '0;
    end else begin
      tx_ready_d <= tx_ready_i;
      rx_full_d  <= rx_full_i;
      ipend      <= (ipend & ~iclr) | ireq;       // Set wins over clear
    end
  end

  // Highest slot number wins
  always_comb begin
    ivec_o = '0;
    for (int i = 1; i < IRQ_NUM; i++) begin
      if (ipend[i]) begin
        ivec_o = 3'(i);
      end
    end
  end

  assign irq_o     = |ipend;
  assign ipend_o   = ipend;
  assign t_count_o = count;

endmodule

/* source/wb_bridge.sv */
// Wishbone master bridge
// Holds the bus address and the assembled write word, runs single read
// or write cycles and holds the processor while a cycle is open

module wb_bridge (
  input  logic                                clk,
  input  logic                                p_reset_n,
  input  logic                                adr_wr_i,       // Load address
  input  logic                                dlo_wr_i,       // Load data 23:0
  input  logic                                dhi_wr_i,       // Load data 31:24, start write
  input  logic                                rd_go_i,        // Start read
  input  logic [mcu_io_pkg::IO_WIDTH-1:0]     wdata_i,
  output logic [mcu_io_pkg::WB_DATA_W-1:0]    rdata_o,        // Captured read data
  output logic                                hold_o,         // Processor stall
  // Bus side
  output logic [mcu_io_pkg::WB_ADDR_W-1:0]    adr_o,
  output logic [mcu_io_pkg::WB_DATA_W-1:0]    dat_o,
  input  logic [mcu_io_pkg::WB_DATA_W-1:0]    dat_i,
  output logic                                we_o,
  output logic                                stb_o,
  input  logic                                ack_i
);
  import mcu_io_pkg::*;

  logic busy;                                     // Bus cycle open
  logic start;

  assign start = (dhi_wr_i | rd_go_i) & ~busy;

  always_ff @(posedge clk) begin
    if (!p_reset_n) begin
      busy <= 1'b0;
      we_o <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      we_o <= dhi_wr_i;                           // 1 write, 0 read
    end else if (busy && ack_i) begin
      busy <= 1'b0;                               // Drops the cycle after ack
      we_o <= 1'b0;
    end
  end

  // Address and write word stay put while stb_o is high
  always_ff @(posedge clk) begin
    if (adr_wr_i && !busy) begin
      adr_o <= wdata_i[WB_ADDR_W-1:0];
    end
    if (dlo_wr_i && !busy) begin
      dat_o[IO_WIDTH-1:0] <= wdata_i;
    end
    if (dhi_wr_i && !busy) begin
      dat_o[WB_DATA_W-1:IO_WIDTH] <= wdata_i[WB_DATA_W-IO_WIDTH-1:0];
    end
    if (busy && ack_i && !we_o) begin
      rdata_o <= dat_i;                           // Read data in the ack cycle
    end
  end

  assign stb_o  = busy;
  assign hold_o = busy;

endmodule

/* source/mcu_io.sv */
// MCU I/O hub
// Connects the processor I/O port to the UART, interrupt controller
// and Wishbone bridge through the I/O decoder

module mcu_io (
  input  logic                                clk,
  input  logic                                p_reset_n,
  // Processor I/O port
  input  logic                                io_rd_i,
  input  logic                                io_wr_i,
  input  logic [mcu_io_pkg::IO_ADDR_W-1:0]    io_addr_i,
  input  logic [mcu_io_pkg::IO_WIDTH-1:0]     io_din_i,
  output logic [mcu_io_pkg::IO_WIDTH-1:0]     io_dout_o,
  output logic                                hold_o,         // Stall while bus busy
  // Serial line
  input  logic                                rxd_i,
  output logic                                txd_o,
  // Wishbone master
  output logic [mcu_io_pkg::WB_ADDR_W-1:0]    adr_o,
  output logic [mcu_io_pkg::WB_DATA_W-1:0]    dat_o,
  input  logic [mcu_io_pkg::WB_DATA_W-1:0]    dat_i,
  output logic                                we_o,
  output logic                                stb_o,
  input  logic                                ack_i,
  // Interrupts
  input  logic [mcu_io_pkg::IRQS-1:0]         irqs_i,
  input  logic                                iack_i,
  output logic                                irq_o,
  output logic [2:0]                          ivec_o
);
  import mcu_io_pkg::*;

  logic                 u_wr;                     // UART strobes and status
  logic                 u_rd;
  logic [7:0]           u_rx_data;
  logic                 u_tx_ready;
  logic                 u_rx_full;
  logic                 t_wr;                     // Timer load
  logic [IO_WIDTH-1:0]  t_count;
  logic [IRQ_NUM-1:0]   ipend;
  logic                 wb_adr_wr;                // Bridge strobes
  logic                 wb_dlo_wr;
  logic                 wb_dhi_wr;
  logic                 wb_rd_go;
  logic [WB_DATA_W-1:0] wb_rdata;

  io_decode dec0 (
    .clk(clk), .p_reset_n(p_reset_n),
    .io_rd_i(io_rd_i), .io_wr_i(io_wr_i), .io_addr_i(io_addr_i),
    .io_din_i(io_din_i), .io_dout_o(io_dout_o),
    .u_wr_o(u_wr), .u_rd_o(u_rd), .u_rx_data_i(u_rx_data),
    .u_tx_ready_i(u_tx_ready), .u_rx_full_i(u_rx_full),
    .t_wr_o(t_wr), .t_count_i(t_count), .ipend_i(ipend),
    .wb_adr_wr_o(wb_adr_wr), .wb_dlo_wr_o(wb_dlo_wr), .wb_dhi_wr_o(wb_dhi_wr),
    .wb_rd_go_o(wb_rd_go), .wb_rdata_i(wb_rdata)
  );

  uart uart0 (
    .clk(clk), .p_reset_n(p_reset_n),
    .wr_i(u_wr), .din_i(io_din_i[7:0]), .ready_o(u_tx_ready),
    .rd_i(u_rd), .dout_o(u_rx_data), .full_o(u_rx_full),
    .rxd_i(rxd_i), .txd_o(txd_o)
  );

  irq_ctrl irq0 (
    .clk(clk), .p_reset_n(p_reset_n),
    .t_wr_i(t_wr), .t_period_i(io_din_i), .t_count_o(t_count),
    .tx_ready_i(u_tx_ready), .rx_full_i(u_rx_full), .irqs_i(irqs_i),
    .iack_i(iack_i), .ipend_o(ipend), .irq_o(irq_o), .ivec_o(ivec_o)
  );

  wb_bridge wb0 (
    .clk(clk), .p_reset_n(p_reset_n),
    .adr_wr_i(wb_adr_wr), .dlo_wr_i(wb_dlo_wr), .dhi_wr_i(wb_dhi_wr),
    .rd_go_i(wb_rd_go), .wdata_i(io_din_i), .rdata_o(wb_rdata), .hold_o(hold_o),
    .adr_o(adr_o), .dat_o(dat_o), .dat_i(dat_i),
    .we_o(we_o), .stb_o(stb_o), .ack_i(ack_i)
  );

endmodule

/* tests/tb_mcu_io.sv */
// Testbench for the MCU I/O hub
// Plays the processor on the I/O port and a Wishbone slave on the bus,
// with the serial line looped back onto itself

module tb_mcu_io;
  timeunit 1ns;
  timeprecision 1ps;
  import mcu_io_pkg::*;

  localparam int WAIT_MAX = 400;                  // Cycles or polls per wait

  logic                 clk = 1'b0;
  logic                 p_reset_n = 1'b0;
  logic                 io_rd = 1'b0;             // Processor side
  logic                 io_wr = 1'b0;
  logic [IO_ADDR_W-1:0] io_addr = '0;
  logic [IO_WIDTH-1:0]  io_din = '0;
  logic [IO_WIDTH-1:0]  io_dout;
  logic                 hold;
  wire                  serial;                   // txd_o back into rxd_i
  logic [WB_ADDR_W-1:0] adr;                      // Wishbone side
  logic [WB_DATA_W-1:0] dat_w;
  logic [WB_DATA_W-1:0] dat_r = '0;
  logic                 we;
  logic                 stb;
  logic                 ack = 1'b0;
  logic [IRQS-1:0]      irqs = '0;                // Interrupt side
  logic                 iack = 1'b0;
  logic                 irq;
  logic [2:0]           ivec;

  logic [WB_DATA_W-1:0] mem [16];                 // Slave memory
  logic [WB_DATA_W-1:0] exp_mem [16];             // Expected bus contents
  logic [31:0]          rnd = 32'd54;             // Stimulus LCG state
  logic [31:0]          ack_rnd = 32'd54;         // Slave delay LCG state
  int                   slv_wait;
  int                   last_wait;                // Delay of the latest bus cycle
  logic                 slv_busy = 1'b0;
  logic [IRQ_NUM-1:0]   exp_pend = '0;            // Model pending set
  logic                 vec_track = 1'b0;         // Vector monitor on
  logic [7:0]           m_rx_byte;                // Model read values
  logic                 m_tx_ready;
  logic                 m_rx_full;
  logic [WB_DATA_W-1:0] m_rdata;
  int                   n_checks = 0;
  int                   n_errors = 0;

  always #20 clk = ~clk;

  mcu_io dut0 (
    .clk(clk), .p_reset_n(p_reset_n),
    .io_rd_i(io_rd), .io_wr_i(io_wr), .io_addr_i(io_addr), .io_din_i(io_din),
    .io_dout_o(io_dout), .hold_o(hold), .rxd_i(serial), .txd_o(serial),
    .adr_o(adr), .dat_o(dat_w), .dat_i(dat_r), .we_o(we), .stb_o(stb), .ack_i(ack),
    .irqs_i(irqs), .iack_i(iack), .irq_o(irq), .ivec_o(ivec)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [WB_DATA_W-1:0] fill_word(input int i);
    return {8'hc3, 8'(i), 8'(i * 7), 8'(~i)};     // Distinct per entry
  endfunction

  // High write cell gives bits 31:24, low cell bits 23:0
  function automatic logic [WB_DATA_W-1:0] ref_bus(input logic [IO_WIDTH-1:0] hi,
                                                   input logic [IO_WIDTH-1:0] lo);
    return {hi[7:0], lo};
  endfunction

  function automatic logic [2:0] ref_vec(input logic [IRQ_NUM-1:0] pend);
    logic [2:0] v;
    v = 3'd0;
    for (int i = IRQ_NUM - 1; i >= 1; i--) begin
      if (pend[i] && v == 3'd0) begin
        v = 3'(i);                                // First hit from the top
      end
    end
    return v;
  endfunction

  function automatic logic [IO_WIDTH-1:0] exp_read(input logic [IO_ADDR_W-1:0] a);
    case (a)
      A_UART_DATA: return IO_WIDTH'(m_rx_byte);
      A_UART_STAT: return IO_WIDTH'({m_rx_full, m_tx_ready});
      A_IRQ_PEND:  return IO_WIDTH'(exp_pend);
      A_WB_DLO:    return m_rdata[IO_WIDTH-1:0];
      A_WB_DHI:    return IO_WIDTH'(m_rdata[WB_DATA_W-1:IO_WIDTH]);
      default:     return '0;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [IO_WIDTH-1:0] got,
                            input logic [IO_WIDTH-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t ns %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_max(input string name, input logic [IO_WIDTH-1:0] got,
                           input logic [IO_WIDTH-1:0] lim);
    n_checks++;
    if (got > lim) begin
      n_errors++;
      $display("FAIL %0t ns %s got %h exp at most %h", $time, name, got, lim);
    end
  endtask

  task automatic check_bus(input string name, input logic [WB_DATA_W-1:0] got,
                           input logic [WB_DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t ns %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_vec(input string name, input logic [2:0] got, input logic [2:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t ns %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t ns %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic wait_hold_low();
    int n;
    n = 0;
    while (hold && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (hold) report_timeout("hold_o to fall");
  endtask

  task automatic io_write(input logic [IO_ADDR_W-1:0] a, input logic [IO_WIDTH-1:0] d);
    wait_hold_low();
    io_wr = 1'b1;
    io_addr = a;
    io_din = d;
    @(negedge clk);
    io_wr = 1'b0;
  endtask

  task automatic io_read(input logic [IO_ADDR_W-1:0] a, output logic [IO_WIDTH-1:0] d);
    wait_hold_low();
    io_rd = 1'b1;
    io_addr = a;
    @(negedge clk);
    io_rd = 1'b0;
    d = io_dout;                                  // Registered one cycle after io_rd
  endtask

  task automatic read_check(input logic [IO_ADDR_W-1:0] a, input string name);
    logic [IO_WIDTH-1:0] d;
    io_read(a, d);
    check_word(name, d, exp_read(a));
  endtask

  task automatic poll_status(input logic [1:0] mask, input string what);
    logic [IO_WIDTH-1:0] d;
    int n;
    n = 0;
    d = '0;
    while ((d[1:0] & mask) != mask && n < WAIT_MAX) begin
      io_read(A_UART_STAT, d);
      n++;
    end
    if ((d[1:0] & mask) != mask) report_timeout(what);
  endtask

  task automatic ack_irq();
    iack = 1'b1;
    exp_pend <= exp_pend & ~(IRQ_NUM'(1) << ref_vec(exp_pend));  // Top slot goes
    @(negedge clk);
    iack = 1'b0;
  endtask

  // Watches one bus cycle from the first stb_o cycle until it closes
  task automatic watch_cycle(input logic [WB_ADDR_W-1:0] a, input logic wr,
                             input logic [WB_DATA_W-1:0] word);
    int n;
    n = 0;
    while (stb && n < WAIT_MAX) begin
      check_bit("we_o", we, wr);
      check_bit("hold_o", hold, 1'b1);
      check_word("adr_o", IO_WIDTH'(adr), IO_WIDTH'(a));
      if (wr) check_bus("dat_o", dat_w, word);
      n++;
      @(negedge clk);
    end
    if (stb) report_timeout("ack on the bus");
    check_bit("hold_o", hold, 1'b0);
    check_word("hold_o cycles", IO_WIDTH'(n), IO_WIDTH'(last_wait + 1));
  endtask

  // Wishbone slave, ack after 0 to 3 idle cycles
  always @(negedge clk) begin
    if (!p_reset_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] = fill_word(i);
      end
      ack = 1'b0;
      slv_busy = 1'b0;
    end else if (ack) begin
      ack = 1'b0;                                 // One-cycle ack
    end else if (stb) begin
      if (!slv_busy) begin
        ack_rnd = lcg_next(ack_rnd);
        slv_wait = int'(ack_rnd[29:28]);
        last_wait = slv_wait;
        slv_busy = 1'b1;
      end
      if (slv_wait == 0) begin
        ack = 1'b1;
        slv_busy = 1'b0;
        if (we) begin
          mem[adr[3:0]] = dat_w;
        end else begin
          dat_r = mem[adr[3:0]];
        end
      end else begin
        slv_wait--;
      end
    end
  end

  // Vector and request line against the model pending set
  always @(negedge clk) begin
    if (vec_track) begin
      check_vec("ivec_o", ivec, ref_vec(exp_pend));
      check_bit("irq_o", irq, |exp_pend);
    end
  end

  initial begin
    logic [IO_WIDTH-1:0]  d;
    logic [IO_WIDTH-1:0]  hi;
    logic [IO_WIDTH-1:0]  lo;
    logic [IO_WIDTH-1:0]  period;
    logic [WB_ADDR_W-1:0] addrs [4];
    int                   n;
    for (int i = 0; i < 16; i++) begin
      exp_mem[i] = fill_word(i);
    end
    repeat (2) @(negedge clk);
    p_reset_n = 1'b1;

    // Reset state
    check_bit("stb_o", stb, 1'b0);
    check_bit("we_o", we, 1'b0);
    check_bit("hold_o", hold, 1'b0);
    check_bit("irq_o", irq, 1'b0);
    check_bit("txd_o", serial, 1'b1);             // Line idles high
    check_vec("ivec_o", ivec, 3'd0);
    m_tx_ready = 1'b1;
    m_rx_full = 1'b0;
    read_check(A_UART_STAT, "io_dout_o status");
    read_check(A_IRQ_PEND, "io_dout_o pending");

    // UART loopback
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next(rnd);
      m_rx_byte = rnd[23:16];
      io_write(A_UART_DATA, IO_WIDTH'(m_rx_byte));
      poll_status(2'b10, "rx full after a sent byte");
      read_check(A_UART_DATA, "io_dout_o rx byte");
      poll_status(2'b01, "tx ready after a frame");
      read_check(A_UART_STAT, "io_dout_o status");
    end

    // Wishbone writes, then reads back
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next(rnd);
      addrs[i] = rnd[30:16];
      rnd = lcg_next(rnd);
      hi = rnd[31:8];                             // Upper 16 bits are ignored
      rnd = lcg_next(rnd);
      lo = rnd[31:8];
      exp_mem[addrs[i][3:0]] = ref_bus(hi, lo);
      io_write(A_WB_ADR, IO_WIDTH'(addrs[i]));
      io_write(A_WB_DLO, lo);
      io_write(A_WB_DHI, hi);
      watch_cycle(addrs[i], 1'b1, ref_bus(hi, lo));
    end
    for (int i = 0; i < 4; i++) begin
      io_write(A_WB_ADR, IO_WIDTH'(addrs[i]));
      io_write(A_WB_RD, '0);
      watch_cycle(addrs[i], 1'b0, '0);
      m_rdata = exp_mem[addrs[i][3:0]];
      read_check(A_WB_DLO, "io_dout_o bus low");
      read_check(A_WB_DHI, "io_dout_o bus high");
    end

    // Interrupt priority, old UART requests cleared first
    n = 0;
    while (irq && n < 16) begin
      ack_irq();
      n++;
    end
    if (irq) report_timeout("irq_o to fall while clearing old requests");
    exp_pend <= '0;
    irqs = 2'b11;
    @(negedge clk);
    irqs = 2'b00;
    rnd = lcg_next(rnd);
    m_rx_byte = rnd[23:16];
    io_write(A_UART_DATA, IO_WIDTH'(m_rx_byte));
    poll_status(2'b11, "rx full and tx ready");
    read_check(A_UART_DATA, "io_dout_o rx byte");
    exp_pend <= IRQ_NUM'((3 << IRQ_EXT0) | (1 << IRQ_URX) | (1 << IRQ_UTX));
    read_check(A_IRQ_PEND, "io_dout_o pending");
    vec_track <= 1'b1;
    n = 0;
    while (irq && n < 16) begin
      ack_irq();
      n++;
    end
    if (irq) report_timeout("irq_o to fall after acknowledges");
    vec_track <= 1'b0;
    read_check(A_IRQ_PEND, "io_dout_o pending");

    // Cycle timer
    rnd = lcg_next(rnd);
    period = IO_WIDTH'(rnd[19:16]) + IO_WIDTH'(3);
    io_write(A_TIMER, period);
    n = 0;
    while (!irq && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (!irq) report_timeout("the timer interrupt");
    exp_pend <= IRQ_NUM'(1 << IRQ_CYCLE);
    read_check(A_IRQ_PEND, "io_dout_o pending");
    for (int i = 0; i < 8; i++) begin
      io_read(A_TIMER, d);
      check_max("io_dout_o timer", d, period);
    end
    io_write(A_TIMER, '0);                        // Timer off
    check_vec("ivec_o", ivec, ref_vec(exp_pend));
    ack_irq();
    for (int i = 0; i < 80; i++) begin
      check_bit("irq_o", irq, 1'b0);
      @(negedge clk);
    end

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Stops a run that never reaches the end
  initial begin
    #1000000;
    $display("Run stopped by the watchdog at %0t ns", $time);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* sources.f */
source/mcu_io_pkg.sv
source/io_decode.sv
source/uart.sv
source/irq_ctrl.sv
source/wb_bridge.sv
source/mcu_io.sv
tests/tb_mcu_io.sv

/* Makefile */
# Verilator build and run for the MCU I/O hub testbench

TOP = tb_mcu_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f

# Passes only when the pass line shows up in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
